// File: alu.sv
module alu (
    input  mips_pkg::aluOp_t op,
    input  mips_pkg::word_t  x,
    input  mips_pkg::word_t  y,
    output mips_pkg::word_t  result,
    output logic             zero
);
    import mips_pkg::*;

    logic lessThan;

    // slt compares as two's complement
    assign lessThan = $signed(x) < $signed(y);

    always_comb begin
        case (op)
            ALU_ADD: result = x + y;
            ALU_SUB: result = x - y;
            ALU_AND: result = x & y;
            ALU_OR:  result = x | y;
            ALU_SLT: result = {31'b0, lessThan};
            // Immediate moves to the upper half
            ALU_LUI: result = {y[15:0], 16'b0};
            default: result = x + y;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: controller.sv
`include "mips_params.svh"

module controller (
    input  logic            clk,
    input  logic            rst,
    input  mips_pkg::word_t ir,
    ctrl_if.ctrl            ctrlBus
);
    import mips_pkg::*;

    state_t  state;
    state_t  nextState;
    opcode_t opcode;
    funct_t  funct;
    logic    isRtype;
    logic    isOri;
    logic    isLui;
    logic    isLoad;
    logic    isStore;
    logic    isBeq;
    logic    isJump;

    assign opcode = ir[31:26];
    assign funct  = ir[5:0];

    assign isRtype = (opcode == `OP_RTYPE);
    assign isOri   = (opcode == `OP_ORI);
    assign isLui   = (opcode == `OP_LUI);
    assign isLoad  = (opcode == `OP_LW);
    assign isStore = (opcode == `OP_SW);
    assign isBeq   = (opcode == `OP_BEQ);
    assign isJump  = (opcode == `OP_J);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            FETCH:  nextState = DECODE;
            DECODE: nextState = EXEC;
            EXEC: begin
                if (isLoad || isStore) begin
                    nextState = MEM;
                end else if (isRtype || isOri || isLui) begin
                    nextState = WB;
                end else begin
                    // beq, j and unknown opcodes finish here
                    nextState = FETCH;
                end
            end
            MEM:     nextState = isLoad ? WB : FETCH;
            default: nextState = FETCH;
        endcase
    end

    // Selects follow the opcode and stay stable while the IR holds
    always_comb begin
        ctrlBus.regDst  = isRtype ? DST_RD : DST_RT;
        ctrlBus.aluSrc  = (isRtype || isBeq) ? SRC_B : SRC_IMM;
        ctrlBus.mem2Reg = isLoad ? WB_MEM : WB_ALU;
        ctrlBus.extOp   = (isLoad || isStore) ? EXT_SIGN : EXT_ZERO;
        ctrlBus.aluOp   = ALU_ADD;
        if (isRtype) begin
            case (funct)
                `FN_SUBU: ctrlBus.aluOp = ALU_SUB;
                `FN_AND:  ctrlBus.aluOp = ALU_AND;
                `FN_OR:   ctrlBus.aluOp = ALU_OR;
                `FN_SLT:  ctrlBus.aluOp = ALU_SLT;
                default:  ctrlBus.aluOp = ALU_ADD;
            endcase
        end else if (isOri) begin
            ctrlBus.aluOp = ALU_OR;
        end else if (isLui) begin
            ctrlBus.aluOp = ALU_LUI;
        end else if (isBeq) begin
            ctrlBus.aluOp = ALU_SUB;
        end
    end

    // Strobes per state, all low for an unknown state
    always_comb begin
        ctrlBus.pcWr   = 1'b0;
        ctrlBus.irWr   = 1'b0;
        ctrlBus.regWr  = 1'b0;
        ctrlBus.memWr  = 1'b0;
        ctrlBus.npcSel = NPC_SEQ;
        case (state)
            FETCH: begin
                ctrlBus.pcWr = 1'b1;
                ctrlBus.irWr = 1'b1;
            end
            EXEC: begin
                if (isJump) begin
                    ctrlBus.pcWr   = 1'b1;
                    ctrlBus.npcSel = NPC_JUMP;
                end else if (isBeq) begin
                    ctrlBus.pcWr   = ctrlBus.zero;
                    ctrlBus.npcSel = NPC_BRANCH;
                end
            end
            MEM:     ctrlBus.memWr = isStore;
            WB:      ctrlBus.regWr = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: ctrl_if.sv
interface ctrl_if;
    import mips_pkg::*;

    // Write strobes
    logic     pcWr;
    logic     irWr;
    logic     regWr;
    logic     memWr;

    // Mux and unit selects
    regDst_t  regDst;
    aluSrc_t  aluSrc;
    mem2Reg_t mem2Reg;
    extOp_t   extOp;
    aluOp_t   aluOp;
    npcSel_t  npcSel;

    // ALU result was zero, used by beq
    logic     zero;

    modport ctrl (
        output pcWr, irWr, regWr, memWr,
        output regDst, aluSrc, mem2Reg, extOp, aluOp, npcSel,
        input  zero
    );

    modport fetch (input pcWr, irWr, npcSel);

    modport dp (
        input  regWr, regDst, aluSrc, mem2Reg, extOp, aluOp,
        output zero
    );

endinterface

// File: datapath.sv
`include "mips_params.svh"

module datapath (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::word_t     ir,
    input  mips_pkg::word_t     readData,
    output mips_pkg::dmemAddr_t dmemAddr,
    output mips_pkg::word_t     storeData,
    output mips_pkg::word_t     branchOff,
    ctrl_if.dp                  ctrlBus
);
    import mips_pkg::*;

    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    regAddr_t    wa;
    logic [15:0] imm;
    word_t       signImm;
    word_t       extImm;
    word_t       rd1;
    word_t       rd2;
    word_t       regA;
    word_t       regB;
    word_t       aluIn;
    word_t       aluResult;
    word_t       aluOut;
    word_t       dataReg;
    word_t       wbData;

    // Instruction fields
    assign rs  = ir[25:21];
    assign rt  = ir[20:16];
    assign rd  = ir[15:11];
    assign imm = ir[15:0];

    assign signImm   = {{16{imm[15]}}, imm};
    assign extImm    = (ctrlBus.extOp == EXT_SIGN) ? signImm : {16'b0, imm};
    // Branch offset is always sign extended
    assign branchOff = signImm;

    assign wa     = (ctrlBus.regDst == DST_RD) ? rd : rt;
    assign aluIn  = (ctrlBus.aluSrc == SRC_IMM) ? extImm : regB;
    assign wbData = (ctrlBus.mem2Reg == WB_MEM) ? dataReg : aluOut;

    gpr i_gpr (
        .clk (clk),
        .we  (ctrlBus.regWr),
        .ra1 (rs),
        .ra2 (rt),
        .wa  (wa),
        .wd  (wbData),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    alu i_alu (
        .op     (ctrlBus.aluOp),
        .x      (regA),
        .y      (aluIn),
        .result (aluResult),
        .zero   (ctrlBus.zero)
    );

    // A, B and ALUOut reload every cycle and hold while the IR is stable
    always_ff @(posedge clk) begin
        if (rst) begin
            regA   <= '0;
            regB   <= '0;
            aluOut <= '0;
        end else begin
            regA   <= rd1;
            regB   <= rd2;
            aluOut <= aluResult;
        end
    end

    // Memory data register
    always_ff @(posedge clk) begin
        dataReg <= readData;
    end

    // Effective address is a word index
    assign dmemAddr  = aluOut[`DMEM_AW-1:0];
    assign storeData = regB;

endmodule

// File: dmem.sv
`include "mips_params.svh"

module dmem (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  mips_pkg::dmemAddr_t addr,
    input  mips_pkg::word_t     wd,
    output mips_pkg::word_t     rd,
    output logic                storeValid,
    output mips_pkg::dmemAddr_t storeAddr,
    output mips_pkg::word_t     storeData
);
    import mips_pkg::*;

    word_t mem [1 << `DMEM_AW];

    // Sweep every word to zero on each reset cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `DMEM_AW); i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wd;
        end
    end

    assign rd = mem[addr];

    // Store report in the cycle of the write, never while reset blocks it
    assign storeValid = we && !rst;
    assign storeAddr  = addr;
    assign storeData  = wd;

endmodule

// File: filelist.f
+incdir+.
mips_pkg.sv
ctrl_if.sv
ifu.sv
gpr.sv
alu.sv
datapath.sv
controller.sv
dmem.sv
mips.sv
tb_mips.sv

// File: gpr.sv
module gpr (
    input  logic               clk,
    input  logic               we,
    input  mips_pkg::regAddr_t ra1,
    input  mips_pkg::regAddr_t ra2,
    input  mips_pkg::regAddr_t wa,
    input  mips_pkg::word_t    wd,
    output mips_pkg::word_t    rd1,
    output mips_pkg::word_t    rd2
);
    import mips_pkg::*;

    word_t regs [32];

    // $zero is never written
    always_ff @(posedge clk) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous read ports
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: ifu.sv
`include "mips_params.svh"

module ifu (
    input  logic                clk,
    input  logic                rst,
    input  logic                progWe,
    input  mips_pkg::imemAddr_t progAddr,
    input  mips_pkg::word_t     progData,
    input  mips_pkg::word_t     branchOff,
    output mips_pkg::word_t     ir,
    output mips_pkg::imemAddr_t pc,
    ctrl_if.fetch               ctrlBus
);
    import mips_pkg::*;

    word_t     imem [1 << `IMEM_AW];
    imemAddr_t nextPc;

    // Program load is only honoured while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst && progWe) begin
            imem[progAddr] <= progData;
        end
    end

    // PC already holds PC+1 once the branch resolves
    always_comb begin
        case (ctrlBus.npcSel)
            NPC_BRANCH: nextPc = pc + branchOff[`IMEM_AW-1:0];
            NPC_JUMP:   nextPc = ir[`IMEM_AW-1:0];
            default:    nextPc = pc + 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= imemAddr_t'(`RESET_PC);
        end else if (ctrlBus.pcWr) begin
            pc <= nextPc;
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (ctrlBus.irWr) begin
            ir <= imem[pc];
        end
    end

endmodule

// File: mips.sv
module mips (
    input  logic                clk,
    input  logic                rst,
    input  logic                progWe,
    input  mips_pkg::imemAddr_t progAddr,
    input  mips_pkg::word_t     progData,
    output logic                storeValid,
    output mips_pkg::dmemAddr_t storeAddr,
    output mips_pkg::word_t     storeData
);
    import mips_pkg::*;

    ctrl_if ctrlBus ();

    word_t     ir;
    word_t     branchOff;
    word_t     readData;
    word_t     memWrData;
    dmemAddr_t dmemAddr;

    // Input side
    ifu i_ifu (
        .clk       (clk),
        .rst       (rst),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .branchOff (branchOff),
        .ir        (ir),
        .pc        (),
        .ctrlBus   (ctrlBus.fetch)
    );

    controller i_controller (
        .clk     (clk),
        .rst     (rst),
        .ir      (ir),
        .ctrlBus (ctrlBus.ctrl)
    );

    datapath i_datapath (
        .clk       (clk),
        .rst       (rst),
        .ir        (ir),
        .readData  (readData),
        .dmemAddr  (dmemAddr),
        .storeData (memWrData),
        .branchOff (branchOff),
        .ctrlBus   (ctrlBus.dp)
    );

    // Output side
    dmem i_dmem (
        .clk        (clk),
        .rst        (rst),
        .we         (ctrlBus.memWr),
        .addr       (dmemAddr),
        .wd         (memWrData),
        .rd         (readData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

endmodule

// File: mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Memory depths as address widths in words
`define IMEM_AW 8
`define DMEM_AW 8

// Word index of the first instruction
`define RESET_PC 0

// Primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_ORI   6'h0d
`define OP_LUI   6'h0f
`define OP_LW    6'h23
`define OP_SW    6'h2b

// Funct field of R-type instructions
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2a

`endif

// File: mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

    typedef logic [31:0]         word_t;
    typedef logic [4:0]          regAddr_t;
    typedef logic [5:0]          opcode_t;
    typedef logic [5:0]          funct_t;
    typedef logic [`IMEM_AW-1:0] imemAddr_t;
    typedef logic [`DMEM_AW-1:0] dmemAddr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } aluOp_t;

    typedef enum logic {DST_RT, DST_RD} regDst_t;
    typedef enum logic {SRC_B, SRC_IMM} aluSrc_t;
    typedef enum logic {WB_ALU, WB_MEM} mem2Reg_t;
    typedef enum logic {EXT_ZERO, EXT_SIGN} extOp_t;
    typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JUMP} npcSel_t;

    // Multicycle phases
    typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, WB} state_t;

endpackage

// File: tb_mips.sv
`include "mips_params.svh"

module tb_mips;
    timeunit 1ns;
    timeprecision 100ps;

    import mips_pkg::*;

    logic      clk;
    logic      rst;
    logic      progWe;
    imemAddr_t progAddr;
    word_t     progData;
    logic      storeValid;
    dmemAddr_t storeAddr;
    word_t     storeData;

    // Program image and the store stream expected from the model
    word_t     prog [$];
    dmemAddr_t expAddr [$];
    word_t     expData [$];

    logic [31:0] lfsrState;
    int nInstr;
    int modelCycles;
    int expCount = 0;
    int seen = 0;
    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int cycleCount = 0;
    int cycleLimit = 16;

    mips i_dut (
        .clk        (clk),
        .rst        (rst),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, the core stopped producing stores", cycleCount);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // Random programs only touch r0 to r4
    function automatic regAddr_t pickReg();
        return regAddr_t'(takeBits(3) % 5);
    endfunction

    // Instruction encoders in assembler operand order
    function automatic word_t rType(input funct_t fn, input regAddr_t rd, input regAddr_t rs,
                                    input regAddr_t rt);
        return {6'(`OP_RTYPE), rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic word_t iType(input opcode_t op, input regAddr_t rt, input regAddr_t rs,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jType(input int target);
        return {6'(`OP_J), 26'(target)};
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic checkWord(input string name, input int idx, input word_t got,
                             input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s in store %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkAddr(input string name, input int idx, input dmemAddr_t got,
                             input dmemAddr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s in store %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
            errorCount++;
        end
    endtask

    // Store monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            if (storeValid !== 1'b0) begin
                $display("storeValid was not low while rst was high");
                errorCount++;
            end
        end else if (storeValid !== 1'b0) begin
            if (seen < expCount) begin
                checkAddr("storeAddr", seen, storeAddr, expAddr[seen]);
                checkWord("storeData", seen, storeData, expData[seen]);
            end else begin
                $display("Unexpected store of 0x%h to address 0x%h after the expected ones",
                         storeData, storeAddr);
                errorCount++;
            end
            seen++;
        end
    end

    // Instruction-set model that runs until the closing jump to itself
    task automatic runModel();
        word_t     regs [32];
        word_t     mem [1 << `DMEM_AW];
        imemAddr_t pc;
        imemAddr_t curPc;
        word_t     inst;
        regAddr_t  rs;
        regAddr_t  rt;
        regAddr_t  rd;
        word_t     a;
        word_t     b;
        word_t     sext;
        dmemAddr_t addr;
        logic      done;
        nInstr = 0;
        modelCycles = 0;
        expAddr.delete();
        expData.delete();
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
        pc = imemAddr_t'(`RESET_PC);
        done = 1'b0;
        while (!done) begin
            if (pc >= prog.size() || nInstr > 500) begin
                $display("Reference model ran off the program at word %0d", pc);
                errorCount++;
                done = 1'b1;
            end else begin
                inst = prog[pc];
                rs = inst[25:21];
                rt = inst[20:16];
                rd = inst[15:11];
                a = regs[rs];
                b = regs[rt];
                sext = {{16{inst[15]}}, inst[15:0]};
                addr = dmemAddr_t'(a + sext);
                curPc = pc;
                pc = pc + 1'b1;
                nInstr++;
                case (inst[31:26])
                    `OP_RTYPE: begin
                        case (inst[5:0])
                            `FN_SUBU: regs[rd] = a - b;
                            `FN_AND:  regs[rd] = a & b;
                            `FN_OR:   regs[rd] = a | b;
                            `FN_SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            default:  regs[rd] = a + b;
                        endcase
                        modelCycles += 4;
                    end
                    `OP_ORI: begin
                        regs[rt] = a | {16'h0000, inst[15:0]};
                        modelCycles += 4;
                    end
                    `OP_LUI: begin
                        regs[rt] = {inst[15:0], 16'h0000};
                        modelCycles += 4;
                    end
                    `OP_LW: begin
                        regs[rt] = mem[addr];
                        modelCycles += 5;
                    end
                    `OP_SW: begin
                        mem[addr] = b;
                        expAddr.push_back(addr);
                        expData.push_back(b);
                        modelCycles += 4;
                    end
                    `OP_BEQ: begin
                        if (a == b) begin
                            pc = pc + sext[`IMEM_AW-1:0];
                        end
                        modelCycles += 3;
                    end
                    `OP_J: begin
                        done = (inst[`IMEM_AW-1:0] == curPc);
                        pc = inst[`IMEM_AW-1:0];
                        modelCycles += 3;
                    end
                    default: modelCycles += 3;
                endcase
                regs[0] = '0;
            end
        end
    endtask

    // Loads the program during reset and follows the store stream
    task automatic runProgram(input string name, input bit cutShort);
        int startErrors;
        int budget;
        int cyc;
        startErrors = errorCount;
        runModel();
        budget = 5 * nInstr + 20;
        cycleLimit += 16 + budget + 8;
        seen = 0;
        expCount = expData.size();
        rst = 1'b1;
        for (int i = 0; i < 16; i++) begin
            progAddr = imemAddr_t'(i);
            progWe = (i < prog.size());
            if (i < prog.size()) begin
                progData = prog[i];
            end else begin
                progData = '0;
            end
            nextCycle();
        end
        progWe = 1'b0;
        rst = 1'b0;
        cyc = 0;
        if (cutShort) begin
            // Stop inside the second store so the next reset lands on it
            while (!(seen > 0 && storeValid === 1'b1) && cyc < budget) begin
                nextCycle();
                cyc++;
            end
            if (storeValid !== 1'b1) begin
                $display("%s: no second store arrived for the reset to interrupt", name);
                errorCount++;
            end
        end else begin
            while ((seen < expCount || cyc < modelCycles + 2) && cyc < budget) begin
                nextCycle();
                cyc++;
            end
            if (seen < expCount) begin
                $display("%s: only %0d of %0d expected stores arrived", name, seen, expCount);
                errorCount++;
            end
        end
        testsRun++;
        if (errorCount == startErrors) begin
            $display("%s: %0d stores checked, ok", name, seen);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, errorCount - startErrors);
        end
    endtask

    task automatic buildArith();
        prog.delete();
        emit(iType(`OP_ORI, 5'd1, 5'd0, 16'h00f0));
        // Negative operand for the signed compare
        emit(iType(`OP_LUI, 5'd2, 5'd0, 16'hffff));
        emit(iType(`OP_ORI, 5'd2, 5'd2, 16'h0f0f));
        emit(rType(`FN_ADDU, 5'd3, 5'd1, 5'd2));
        emit(iType(`OP_SW, 5'd3, 5'd0, 16'd0));
        emit(rType(`FN_SUBU, 5'd3, 5'd1, 5'd2));
        emit(iType(`OP_SW, 5'd3, 5'd0, 16'd1));
        emit(rType(`FN_AND, 5'd3, 5'd1, 5'd2));
        emit(iType(`OP_SW, 5'd3, 5'd0, 16'd2));
        emit(rType(`FN_OR, 5'd3, 5'd1, 5'd2));
        emit(iType(`OP_SW, 5'd3, 5'd0, 16'd3));
        emit(rType(`FN_SLT, 5'd3, 5'd2, 5'd1));
        emit(iType(`OP_SW, 5'd3, 5'd0, 16'd4));
        emit(rType(`FN_SLT, 5'd3, 5'd1, 5'd2));
        emit(iType(`OP_SW, 5'd3, 5'd0, 16'd5));
        emit(jType(15));
    endtask

    task automatic buildImmediates();
        prog.delete();
        emit(iType(`OP_LUI, 5'd1, 5'd0, 16'h8001));
        emit(iType(`OP_ORI, 5'd1, 5'd1, 16'hfffe));
        emit(iType(`OP_SW, 5'd1, 5'd0, 16'h0010));
        emit(iType(`OP_ORI, 5'd2, 5'd0, 16'h8000));
        emit(iType(`OP_SW, 5'd2, 5'd0, 16'h0011));
        emit(iType(`OP_ORI, 5'd3, 5'd0, 16'h0020));
        emit(iType(`OP_SW, 5'd3, 5'd3, 16'hffff));
        emit(iType(`OP_BEQ, 5'd0, 5'd0, 16'd3));
        emit(iType(`OP_SW, 5'd1, 5'd0, 16'h0012));
        emit(iType(`OP_SW, 5'd2, 5'd0, 16'h0013));
        emit(jType(13));
        // Backward offset lands on word 9
        emit(iType(`OP_BEQ, 5'd0, 5'd0, 16'hfffd));
        emit(iType(`OP_SW, 5'd1, 5'd0, 16'h0014));
        emit(iType(`OP_SW, 5'd3, 5'd0, 16'h0015));
        emit(jType(14));
    endtask

    task automatic buildMemory();
        prog.delete();
        emit(iType(`OP_LUI, 5'd1, 5'd0, 16'hdead));
        emit(iType(`OP_ORI, 5'd1, 5'd1, 16'hbeef));
        emit(iType(`OP_ORI, 5'd2, 5'd0, 16'h0040));
        emit(iType(`OP_SW, 5'd1, 5'd2, 16'd3));
        emit(iType(`OP_LW, 5'd3, 5'd2, 16'd3));
        emit(iType(`OP_SW, 5'd3, 5'd0, 16'd0));
        // Writes aimed at r0 must vanish
        emit(rType(`FN_ADDU, 5'd0, 5'd1, 5'd1));
        emit(iType(`OP_ORI, 5'd0, 5'd0, 16'h0055));
        emit(iType(`OP_LW, 5'd0, 5'd2, 16'd3));
        emit(iType(`OP_SW, 5'd0, 5'd0, 16'd1));
        emit(rType(`FN_ADDU, 5'd4, 5'd0, 5'd3));
        emit(iType(`OP_SW, 5'd4, 5'd0, 16'd2));
        emit(jType(12));
    endtask

    task automatic buildControl();
        prog.delete();
        emit(iType(`OP_ORI, 5'd1, 5'd0, 16'd5));
        emit(iType(`OP_ORI, 5'd2, 5'd0, 16'd5));
        emit(iType(`OP_ORI, 5'd3, 5'd0, 16'd7));
        emit(iType(`OP_BEQ, 5'd3, 5'd1, 16'd2));
        emit(iType(`OP_SW, 5'd1, 5'd0, 16'h0020));
        emit(iType(`OP_BEQ, 5'd2, 5'd1, 16'd2));
        emit(iType(`OP_SW, 5'd2, 5'd0, 16'h0021));
        emit(iType(`OP_SW, 5'd3, 5'd0, 16'h0022));
        emit(jType(10));
        emit(iType(`OP_SW, 5'd1, 5'd0, 16'h0023));
        emit(iType(`OP_SW, 5'd3, 5'd0, 16'h0024));
        emit(jType(11));
    endtask

    // Straight-line body with forward branches and a closing jump at word 15
    task automatic buildRandom();
        int       kind;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        prog.delete();
        for (int r = 1; r < 5; r++) begin
            emit(iType(`OP_ORI, regAddr_t'(r), 5'd0, 16'(takeBits(16))));
        end
        for (int idx = 4; idx < 15; idx++) begin
            kind = int'(takeBits(4));
            rs = pickReg();
            rt = pickReg();
            rd = pickReg();
            case (kind)
                0:       emit(rType(`FN_ADDU, rd, rs, rt));
                1:       emit(rType(`FN_SUBU, rd, rs, rt));
                2:       emit(rType(`FN_AND, rd, rs, rt));
                3:       emit(rType(`FN_OR, rd, rs, rt));
                4:       emit(rType(`FN_SLT, rd, rs, rt));
                5:       emit(iType(`OP_ORI, rt, rs, 16'(takeBits(16))));
                6:       emit(iType(`OP_LUI, rt, 5'd0, 16'(takeBits(16))));
                7, 8:    emit(iType(`OP_LW, rt, 5'd0, 16'(takeBits(3))));
                13, 14:  emit(iType(`OP_BEQ, rt, rs, 16'(takeBits(4) % (15 - idx))));
                default: emit(iType(`OP_SW, rt, 5'd0, 16'(takeBits(3))));
            endcase
        end
        emit(jType(15));
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        lfsrState = 32'hf594;
        nextCycle();
        buildArith();
        runProgram("R-type arithmetic", 1'b0);
        buildImmediates();
        runProgram("Immediates", 1'b0);
        buildMemory();
        runProgram("Memory round trip", 1'b0);
        buildControl();
        runProgram("Control flow", 1'b0);
        for (int t = 0; t < 20; t++) begin
            buildRandom();
            runProgram($sformatf("Random program %0d", t), 1'b0);
        end
        // First reload is cut by a reset in the middle of a store, second runs in full
        for (int t = 0; t < 2; t++) begin
            buildArith();
            runProgram($sformatf("Reset reload %0d", t), t == 0);
        end
        $display("Tests run %0d, passed %0d, failed %0d", testsRun, testsRun - testsFailed,
                 testsFailed);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
